// ==== Makefile ====
# Verilator build and run for the streaming vector adder testbench

VERILATOR ?= verilator
TOP       ?= tb_vctr_fifo_strm
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

SOURCES := hsid_pkg.sv hsid_fifo.sv vctr_fifo_strm.sv \
           tb_vctr_fifo_strm.sv tb_vctr_tasks.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, not the simulator exit status
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hsid_fifo.sv ====
`timescale 1ns/1ps

module hsid_fifo #(
  parameter hsid_pkg::fifo_cnt_t almost_full_level =
    hsid_pkg::fifo_cnt_t'(hsid_pkg::buffer_size - 1)
) (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                wr_en,        // Push request
  input  hsid_pkg::hsid_word_t data_in,

  input  logic                rd_en,        // Pop request
  output hsid_pkg::hsid_word_t data_out,    // Head word, registered on pop

  output logic                full,
  output logic                almost_full,  // Count at or above the level
  output logic                empty
);

  import hsid_pkg::*;

  // Storage and pointers
  hsid_word_t                mem [buffer_size];
  logic [buffer_width-1:0]   wr_ptr;
  logic [buffer_width-1:0]   rd_ptr;
  fifo_cnt_t                 count;   // Words held

  // Qualified requests
  logic do_wr;
  logic do_rd;

  // Status flags, straight from the count
  assign full        = (count == fifo_cnt_t'(buffer_size));
  assign empty       = (count == '0);
  assign almost_full = (count >= almost_full_level);

  // Requests against a full or empty buffer are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Write side
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      wr_ptr <= wr_ptr + buffer_width'(1);  // Wraps at buffer_size
    end
  end

  // Read side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_rd) begin
      rd_ptr <= rd_ptr + buffer_width'(1);
    end
  end

  // Popped word stays on data_out until the next pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out <= '0;
    end else if (do_rd) begin
      data_out <= mem[rd_ptr];
    end
  end

  // Occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10: begin
          count <= count + fifo_cnt_t'(1);  // Push only
        end
        2'b01: begin
          count <= count - fifo_cnt_t'(1);  // Pop only
        end
        default: begin
          count <= count;  // Idle, or push and pop together
        end
      endcase
    end
  end

endmodule

// ==== hsid_pkg.sv ====
package hsid_pkg;

  // Band sample
  localparam int word_width = 16;  // Bits per band sample

  // Vector length
  localparam int band_cnt_width = 8;  // Up to 255 bands per pixel

  // Buffering between the stages
  localparam int buffer_width = 2;                  // FIFO address bits
  localparam int buffer_size  = 2 ** buffer_width;  // FIFO entries

  // One band sample, also the width of a sum
  typedef logic [word_width-1:0] hsid_word_t;

  // Vector length and processed count
  typedef logic [band_cnt_width-1:0] band_cnt_t;

  // FIFO occupancy, must reach buffer_size itself
  typedef logic [buffer_width:0] fifo_cnt_t;

  // Controller states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,  // Waiting for start
    st_compute = 2'd1,  // Popping and adding
    st_done    = 2'd2   // Draining the output FIFO
  } vctr_state_t;

endpackage

// ==== tb.f ====
+incdir+.
hsid_pkg.sv
hsid_fifo.sv
vctr_fifo_strm.sv
tb_vctr_fifo_strm.sv

// ==== tb_vctr_tasks.svh ====
`ifndef TB_VCTR_TASKS_SVH
`define TB_VCTR_TASKS_SVH

task automatic check_word(input string name, input hsid_word_t expected,
                          input hsid_word_t actual);
  check_count++;
  assert (actual === expected) else begin
    error_count++;
    $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  check_count++;
  assert (actual === expected) else begin
    error_count++;
    $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
  end
endtask

task automatic check_true(input bit cond, input string what);
  check_count++;
  assert (cond) else begin
    error_count++;
    $display("Error at %0t: %s", $time, what);
  end
endtask

function automatic void push_pair(input hsid_word_t a, input hsid_word_t b);
  v1_q.push_back(a);
  v2_q.push_back(b);
  exp_q.push_back(hsid_word_t'((int'(a) + int'(b)) % 65536));  // Sum modulo 2**16
endfunction

task automatic build_random(input int len);
  hsid_word_t a;
  hsid_word_t b;
  for (int i = 0; i < len; i++) begin
    a = hsid_word_t'($random(seed));
    b = hsid_word_t'($random(seed));
    push_pair(a, b);
  end
endtask

// Word is held on the port until a cycle where full is low
task automatic feed_v1(input int skew, input bit polite);
  repeat (skew) @(posedge clk);
  while (v1_q.size() > 0) begin
    @(posedge clk);
    #2;
    data_in_v1    = v1_q[0];
    data_in_v1_en = polite ? !data_in_v1_full : 1'b1;
    if (!data_in_v1_full) begin
      void'(v1_q.pop_front());  // Taken at the coming edge
    end
  end
  @(posedge clk);
  #2;
  data_in_v1_en = 1'b0;
endtask

task automatic feed_v2(input int skew, input bit polite);
  repeat (skew) @(posedge clk);
  while (v2_q.size() > 0) begin
    @(posedge clk);
    #2;
    data_in_v2    = v2_q[0];
    data_in_v2_en = polite ? !data_in_v2_full : 1'b1;
    if (!data_in_v2_full) begin
      void'(v2_q.pop_front());
    end
  end
  @(posedge clk);
  #2;
  data_in_v2_en = 1'b0;
endtask

task automatic drain_results(input int n, input int stall_at, input int stall_len);
  int         got;
  int         issued;
  int         stall_left;
  bit         stalled;
  logic       pending;
  hsid_word_t expected;
  got        = 0;
  issued     = 0;
  stall_left = 0;
  stalled    = 1'b0;
  pending    = 1'b0;
  while (got < n) begin
    @(posedge clk);
    #2;
    if (pending) begin
      expected = exp_q.pop_front();
      check_word("data_out", expected, data_out);  // Word popped at the last edge
      got++;
    end
    if (!stalled && issued == stall_at) begin
      stall_left = stall_len;
      stalled    = 1'b1;
    end
    if (stall_left > 0) begin
      stall_left--;
      if (stall_left == 1) begin
        check_bit("data_in_v1_full", 1'b1, data_in_v1_full);
        check_bit("data_in_v2_full", 1'b1, data_in_v2_full);
      end
      pending = 1'b0;
    end else begin
      pending = !data_out_empty && (issued < n);
      if (pending) begin
        issued++;
      end
    end
    data_out_en = pending;
  end
  data_out_en = 1'b0;
endtask

task automatic run_vector(input int len, input int skew, input int stall_at,
                          input int stall_len, input bit polite);
  int done_before;
  int extra;
  @(posedge clk);
  #2;
  vector_length = band_cnt_t'(len);
  start         = 1'b1;
  done_before   = done_cycles;
  extra         = 0;
  @(posedge clk);
  #2;
  start = 1'b0;
  check_bit("ready", 1'b1, ready);
  check_bit("idle", 1'b0, idle);
  fork
    feed_v1(0, polite);
    feed_v2(skew, polite);
    drain_results(len, stall_at, stall_len);
  join
  // Any word still readable before idle lies beyond the vector length
  while (!idle) begin
    if (!data_out_empty) begin
      extra++;
    end
    data_out_en = !data_out_empty;
    @(posedge clk);
    #2;
  end
  data_out_en = 1'b0;
  check_true(done_cycles > done_before, "done never went high for this vector");
  check_bit("data_out_empty", 1'b1, data_out_empty);
  check_true(extra == 0, "more sums came out than the vector length");
endtask

`endif

// ==== tb_vctr_fifo_strm.sv ====
`timescale 1ns/1ps

module tb_vctr_fifo_strm;

  import hsid_pkg::*;

  localparam int timeout_cycles = 4000;  // Tests need roughly 1500 cycles

  logic       clk;
  logic       rst_n;
  logic       data_in_v1_en;
  hsid_word_t data_in_v1;
  logic       data_in_v1_full;
  logic       data_in_v2_en;
  hsid_word_t data_in_v2;
  logic       data_in_v2_full;
  logic       data_out_en;
  hsid_word_t data_out;
  logic       data_out_empty;
  band_cnt_t  vector_length;
  logic       start;
  logic       done;
  logic       idle;
  logic       ready;

  // Reference model queues
  hsid_word_t v1_q[$];   // Words still to be written on v1
  hsid_word_t v2_q[$];   // Words still to be written on v2
  hsid_word_t exp_q[$];  // Expected sums in band order

  int seed        = 32'hd154;
  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int done_cycles = 0;   // Cycles seen with done high

  initial clk = 1'b0;
  always #20 clk = ~clk;

  vctr_fifo_strm UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_in_v1_en   (data_in_v1_en),
    .data_in_v1      (data_in_v1),
    .data_in_v1_full (data_in_v1_full),
    .data_in_v2_en   (data_in_v2_en),
    .data_in_v2      (data_in_v2),
    .data_in_v2_full (data_in_v2_full),
    .data_out_en     (data_out_en),
    .data_out        (data_out),
    .data_out_empty  (data_out_empty),
    .vector_length   (vector_length),
    .start           (start),
    .done            (done),
    .idle            (idle),
    .ready           (ready)
  );

  `include "tb_vctr_tasks.svh"

  // Done is sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (done) begin
      done_cycles = done_cycles + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic test_reset_state();
    check_bit("idle", 1'b1, idle);
    check_bit("ready", 1'b0, ready);
    check_bit("done", 1'b0, done);
    check_bit("data_out_empty", 1'b1, data_out_empty);
    check_bit("data_in_v1_full", 1'b1, data_in_v1_full);
    check_bit("data_in_v2_full", 1'b1, data_in_v2_full);
  endtask

  task automatic test_short_vector();
    push_pair(16'h0001, 16'h0002);
    push_pair(16'h1234, 16'h4321);
    push_pair(16'h7fff, 16'h0001);
    run_vector(3, 0, -1, 0, 1'b1);  // Producer writes only while full is low
  endtask

  task automatic test_long_random();
    build_random(200);
    run_vector(200, 0, -1, 0, 1'b0);
  endtask

  task automatic test_back_pressure();
    build_random(100);
    run_vector(100, 0, 30, 50, 1'b0);  // Consumer stalls 50 cycles after 30 reads
  endtask

  task automatic test_wrap_skew();
    push_pair(16'hffff, 16'h0001);  // Wraps to zero
    for (int i = 0; i < 39; i++) begin
      push_pair(hsid_word_t'(65520 - i), hsid_word_t'(32768 + 37 * i));
    end
    run_vector(40, 6, -1, 0, 1'b0);  // v2 starts 6 cycles behind v1
  endtask

  task automatic test_zero_length();
    run_vector(0, 0, -1, 0, 1'b0);
    build_random(20);
    run_vector(20, 2, -1, 0, 1'b1);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n         = 1'b0;
    data_in_v1_en = 1'b0;
    data_in_v1    = '0;
    data_in_v2_en = 1'b0;
    data_in_v2    = '0;
    data_out_en   = 1'b0;
    vector_length = '0;
    start         = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_state();
    test_short_vector();
    test_long_random();
    test_back_pressure();
    test_wrap_skew();
    test_zero_length();

    repeat (4) @(posedge clk);
    $display("Closing report: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vctr_fifo_strm.sv ====
`timescale 1ns/1ps

module vctr_fifo_strm (
  input  logic                 clk,
  input  logic                 rst_n,

  // Producer side, vector 1
  input  logic                 data_in_v1_en,
  input  hsid_pkg::hsid_word_t data_in_v1,
  output logic                 data_in_v1_full,   // Write would not be taken

  // Producer side, vector 2
  input  logic                 data_in_v2_en,
  input  hsid_pkg::hsid_word_t data_in_v2,
  output logic                 data_in_v2_full,

  // Consumer side
  input  logic                 data_out_en,       // Read strobe
  output hsid_pkg::hsid_word_t data_out,          // Valid one cycle after the strobe
  output logic                 data_out_empty,

  // Control
  input  hsid_pkg::band_cnt_t  vector_length,     // Held from start until done
  input  logic                 start,
  output logic                 done,
  output logic                 idle,
  output logic                 ready
);

  import hsid_pkg::*;

  // Controller
  vctr_state_t state;
  vctr_state_t state_nxt;
  band_cnt_t   processed;  // Sums written to the output FIFO

  // Input FIFO status and read data
  logic       in_1_empty;
  logic       in_2_empty;
  logic       in_1_full;
  logic       in_2_full;
  hsid_word_t rd_v1;
  hsid_word_t rd_v2;

  // Output FIFO status
  logic out_almost_full;

  // Write qualification
  logic in_1_wr;
  logic in_2_wr;
  logic out_rd;

  // Pipeline
  logic       pop;      // Both inputs pop this cycle
  logic       pop_vld;  // Read data of a pop is on rd_v1 and rd_v2
  hsid_word_t sum_q;    // Registered band sum
  logic       out_wr;   // sum_q goes into the output FIFO

  // Moore outputs
  assign idle  = (state == st_idle);
  assign ready = (state == st_compute);
  assign done  = (state == st_done);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_compute;
        end
      end
      st_compute: begin
        if (processed == vector_length) begin
          state_nxt = st_done;  // Also taken at once for length 0
        end
      end
      st_done: begin
        if (data_out_empty) begin
          state_nxt = st_idle;  // Consumer has drained every sum
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      processed <= '0;
    end else if (state == st_idle && start) begin
      processed <= '0;  // Fresh count for each vector
    end else if (out_wr) begin
      processed <= processed + band_cnt_t'(1);
    end
  end

  // Writes are refused outside compute and while the output side is backed up
  assign data_in_v1_full = (state != st_compute) || in_1_full || out_almost_full;
  assign data_in_v2_full = (state != st_compute) || in_2_full || out_almost_full;

  assign in_1_wr = data_in_v1_en && !data_in_v1_full;
  assign in_2_wr = data_in_v2_en && !data_in_v2_full;

  assign out_rd = data_out_en && (state != st_idle);

  // Almost-full at buffer_size - 2 leaves room for every pair already popped
  assign pop = (state == st_compute) && !in_1_empty && !in_2_empty && !out_almost_full;

  // Stage 1 waits for the FIFO read data, stage 2 adds and writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_vld <= 1'b0;
      out_wr  <= 1'b0;
    end else begin
      pop_vld <= pop;
      out_wr  <= pop_vld;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (pop_vld) begin
      sum_q <= rd_v1 + rd_v2;  // Wraps modulo 2**word_width
    end
  end

  hsid_fifo vctr_in_1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (in_1_wr),
    .data_in     (data_in_v1),
    .rd_en       (pop),
    .data_out    (rd_v1),
    .full        (in_1_full),
    .almost_full (),
    .empty       (in_1_empty)
  );

  hsid_fifo vctr_in_2 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (in_2_wr),
    .data_in     (data_in_v2),
    .rd_en       (pop),
    .data_out    (rd_v2),
    .full        (in_2_full),
    .almost_full (),
    .empty       (in_2_empty)
  );

  hsid_fifo #(
    .almost_full_level (fifo_cnt_t'(buffer_size - 2))
  ) vctr_out (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (out_wr),
    .data_in     (sum_q),
    .rd_en       (out_rd),
    .data_out    (data_out),
    .full        (),
    .almost_full (out_almost_full),
    .empty       (data_out_empty)
  );

endmodule
